// File: common/rp_config.svh
// Shared constants for the bus regions and the DAC mixer.
// Offsets are byte addresses inside one 1 MB region.
// Samples are 14-bit two's complement, sums one bit wider.

`ifndef RP_CONFIG_SVH
`define RP_CONFIG_SVH

// ----------------------------------------
// DAC data path
`define RP_SAMPLE_W     14              // DAC sample width
`define RP_SUM_W        15              // sum width before saturation
`define RP_SAT_POS      14'h1FFF        // largest positive sample
`define RP_SAT_NEG      14'h2000        // most negative sample

// ----------------------------------------
// region layout and register map
`define RP_REGION_NUM   8               // regions on the system bus
`define RP_REGION_LSB   20              // region field starts here
`define RP_CTRL_REGION  3'd0            // ctrl_regs lives in region 0

`define RP_OFS_LED      20'h00000       // LED register
`define RP_OFS_MIX      20'h00004       // source enable mask
`define RP_OFS_ID       20'h00008       // read-only design ID

`define RP_ID_VALUE     32'h5250_0A01   // design ID

`endif

// File: common/rp_pkg.sv
// Types shared by the bus sequencer, the region decoder and the mixer.
// Address fields follow the region layout in the config header.

`default_nettype none

`include "rp_config.svh"

package rp_pkg;

  typedef logic signed [`RP_SAMPLE_W-1:0] sample_t; // one DAC sample

  typedef struct packed {
    sample_t a;                         // channel a
    sample_t b;                         // channel b
  } dac_pair_t;

  // one address word, seen raw or split into region and offset
  typedef union packed {
    logic [31:0] raw;                   // as latched by the sequencer
    struct packed {
      logic [31-`RP_REGION_LSB-$clog2(`RP_REGION_NUM):0] unused; // ignored
      logic [$clog2(`RP_REGION_NUM)-1:0]                 region; // region select
      logic [`RP_REGION_LSB-1:0]                         offset; // byte offset
    } fields;
  } addr_u;

  typedef struct packed {
    addr_u       addr;                  // target address
    logic [31:0] wdata;                 // write data
    logic [3:0]  sel;                   // byte selects
    logic        wr;                    // 1 write, 0 read
  } sys_req_t;

  typedef struct packed {
    logic [31:0] rdata;                 // read data
    logic        err;                   // access error
  } sys_rsp_t;

  typedef struct packed {
    logic gen_a;                        // generator into channel a
    logic ctl_a;                        // controller into channel a
    logic gen_b;                        // generator into channel b
    logic ctl_b;                        // controller into channel b
  } mix_mask_t;

endpackage

`default_nettype wire

// File: hw/sys_bus/sys_bus_fsm.sv
// Bus transaction sequencer. One transaction in flight at a time.
// Request and response use valid/ready; the regions see a one-cycle
// strobe and answer with ack, in the same cycle or any cycle later.
// The response is held unchanged until rsp_ready_i.

`timescale 1ns/1ps
`default_nettype none

module sys_bus_fsm (
  input  logic             adc_clk,
  input  logic             rst_i,
  // external request
  input  logic             req_valid_i,
  input  rp_pkg::sys_req_t req_i,
  output logic             req_ready_o,
  // external response
  output logic             rsp_valid_o,
  output rp_pkg::sys_rsp_t rsp_o,
  input  logic             rsp_ready_i,
  // towards the decoder
  output logic             stb_o,
  output rp_pkg::sys_req_t bus_req_o,
  input  logic             ack_i,
  input  rp_pkg::sys_rsp_t bus_rsp_i
);

  typedef enum logic [1:0] {
    ST_IDLE,                            // ready for a request
    ST_STB,                             // strobe the regions
    ST_WAIT,                            // waiting for ack
    ST_RSP                              // holding the response
  } state_t;

  state_t           state_q;
  rp_pkg::sys_req_t req_q;              // latched request
  rp_pkg::sys_rsp_t rsp_q;              // captured response

  // ----------------------------------------
  // state register
  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: if (req_valid_i) state_q <= ST_STB;   // request taken
        ST_STB:  state_q <= ack_i ? ST_RSP : ST_WAIT;  // unmapped acks at once
        ST_WAIT: if (ack_i) state_q <= ST_RSP;
        ST_RSP:  if (rsp_ready_i) state_q <= ST_IDLE;  // handshake done
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // ----------------------------------------
  // payload registers
  always_ff @(posedge adc_clk) begin
    if (state_q == ST_IDLE && req_valid_i) begin
      req_q.addr.raw <= req_i.addr.raw; // whole address word
      req_q.wdata    <= req_i.wdata;
      req_q.sel      <= req_i.sel;
      req_q.wr       <= req_i.wr;
    end
    if ((state_q == ST_STB || state_q == ST_WAIT) && ack_i) begin
      rsp_q <= bus_rsp_i;               // frozen until taken
    end
  end

  assign req_ready_o = (state_q == ST_IDLE);
  assign stb_o       = (state_q == ST_STB); // exactly one cycle
  assign bus_req_o   = req_q;               // stable for the whole access
  assign rsp_valid_o = (state_q == ST_RSP);
  assign rsp_o       = rsp_q;

endmodule

`default_nettype wire

// File: hw/sys_bus/sys_bus_decoder.sv
// Region decoder and response mux for the system bus.
// Only region 0 is mapped. Regions 1 to 7 ack in the strobe cycle
// with zero data and no error.
// Purely combinational; the sequencer holds the request stable.

`timescale 1ns/1ps
`default_nettype none

`include "rp_config.svh"

module sys_bus_decoder (
  input  logic             stb_i,
  input  rp_pkg::sys_req_t bus_req_i,
  // region 0
  output logic             ctrl_stb_o,
  input  logic             ctrl_ack_i,
  input  rp_pkg::sys_rsp_t ctrl_rsp_i,
  // back to the sequencer
  output logic             ack_o,
  output rp_pkg::sys_rsp_t bus_rsp_o
);

  logic ctrl_sel;                       // region 0 addressed

  // ----------------------------------------
  // region select
  assign ctrl_sel   = (bus_req_i.addr.fields.region == `RP_CTRL_REGION);
  assign ctrl_stb_o = stb_i & ctrl_sel; // strobe only the mapped region

  // ----------------------------------------
  // response mux
  always_comb begin
    if (ctrl_sel) begin
      ack_o     = ctrl_ack_i;           // ctrl_regs acks a cycle later
      bus_rsp_o = ctrl_rsp_i;
    end else begin
      ack_o           = stb_i;          // unmapped regions ack at once
      bus_rsp_o.rdata = 32'h0;
      bus_rsp_o.err   = 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: hw/dac_mix/ctrl_regs.sv
// Region 0 register file: LED, mixer source mask and design ID.
// Ack comes one cycle after the strobe, and a write is visible from
// the ack cycle on. Both writable registers sit in byte 0, so only
// sel[0] enables them. Unknown offsets read zero with err set.

`timescale 1ns/1ps
`default_nettype none

`include "rp_config.svh"

module ctrl_regs (
  input  logic              adc_clk,
  input  logic              rst_i,
  input  logic              stb_i,
  input  rp_pkg::sys_req_t  bus_req_i,
  output logic              ack_o,
  output rp_pkg::sys_rsp_t  rsp_o,
  output logic [7:0]        led_o,
  output rp_pkg::mix_mask_t mask_o
);

  logic [`RP_REGION_LSB-1:0] ofs;       // byte offset in region
  logic                      wr_b0;     // write to byte 0
  logic [31:0]               rdata_d;
  logic                      err_d;

  assign ofs   = bus_req_i.addr.fields.offset;
  assign wr_b0 = stb_i & bus_req_i.wr & bus_req_i.sel[0];

  // ----------------------------------------
  // registers
  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      led_o  <= 8'h00;
      mask_o <= '1;                     // both sources on, both channels
      ack_o  <= 1'b0;
    end else begin
      ack_o <= stb_i;
      if (wr_b0 && ofs == `RP_OFS_LED) led_o <= bus_req_i.wdata[7:0];
      if (wr_b0 && ofs == `RP_OFS_MIX) mask_o <= rp_pkg::mix_mask_t'(bus_req_i.wdata[3:0]);
    end
  end

  // read decode, unused upper bits are zero
  always_comb begin
    rdata_d = 32'h0;
    err_d   = 1'b0;
    case (ofs)
      `RP_OFS_LED: rdata_d = {24'h0, led_o};
      `RP_OFS_MIX: rdata_d = {28'h0, mask_o};
      `RP_OFS_ID:  rdata_d = `RP_ID_VALUE;  // writes here are dropped
      default:     err_d   = 1'b1;
    endcase
  end

  // response captured with the strobe, shown with ack
  always_ff @(posedge adc_clk) begin
    if (stb_i) begin
      rsp_o.rdata <= rdata_d;
      rsp_o.err   <= err_d;
    end
  end

endmodule

`default_nettype wire

// File: hw/dac_mix/dac_sat_sum.sv
// Two-channel DAC mixer. Per channel, generator plus controller,
// each gated by its mask bit, summed one bit wider and saturated
// back to 14-bit two's complement. One cycle of latency.

`timescale 1ns/1ps
`default_nettype none

`include "rp_config.svh"

module dac_sat_sum (
  input  logic              adc_clk,
  input  logic              rst_i,
  input  rp_pkg::dac_pair_t gen_i,    // generator samples
  input  rp_pkg::dac_pair_t pid_i,    // controller samples
  input  rp_pkg::mix_mask_t mask_i,   // source enables
  output rp_pkg::dac_pair_t dac_o
);

  // masked sum with saturation for one channel
  function automatic rp_pkg::sample_t sat_sum(
    input rp_pkg::sample_t x,
    input rp_pkg::sample_t y,
    input logic            en_x,
    input logic            en_y
  );
    rp_pkg::sample_t              xs;
    rp_pkg::sample_t              ys;
    logic signed [`RP_SUM_W-1:0] sum;
    xs  = en_x ? x : '0;                // disabled source adds nothing
    ys  = en_y ? y : '0;
    sum = xs + ys;                      // sign extended to sum width
    case (sum[`RP_SUM_W-1 -: 2])
      2'b01:   sat_sum = `RP_SAT_POS;   // positive overflow
      2'b10:   sat_sum = `RP_SAT_NEG;   // negative overflow
      default: sat_sum = sum[`RP_SAMPLE_W-1:0];
    endcase
  endfunction

  // ----------------------------------------
  // output register
  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      dac_o <= '0;
    end else begin
      dac_o.a <= sat_sum(gen_i.a, pid_i.a, mask_i.gen_a, mask_i.ctl_a);
      dac_o.b <= sat_sum(gen_i.b, pid_i.b, mask_i.gen_b, mask_i.ctl_b);
    end
  end

endmodule

`default_nettype wire

// File: hw/rp_top.sv
// Top level: bus sequencer, region decoder, region 0 registers and
// the DAC mixer, all on adc_clk. Generator and controller samples
// come straight from the ports.

`timescale 1ns/1ps
`default_nettype none

module rp_top (
  input  logic              adc_clk,
  input  logic              rst_i,
  // bus request
  input  logic              req_valid_i,
  input  rp_pkg::sys_req_t  req_i,
  output logic              req_ready_o,
  // bus response
  output logic              rsp_valid_o,
  output rp_pkg::sys_rsp_t  rsp_o,
  input  logic              rsp_ready_i,
  // DAC path
  input  rp_pkg::dac_pair_t gen_i,
  input  rp_pkg::dac_pair_t pid_i,
  output rp_pkg::dac_pair_t dac_o,
  output logic [7:0]        led_o
);

  logic              stb;               // sequencer strobe
  rp_pkg::sys_req_t  bus_req;           // held request
  logic              ack;               // decoded ack
  rp_pkg::sys_rsp_t  bus_rsp;           // decoded response
  logic              ctrl_stb;          // region 0 strobe
  logic              ctrl_ack;
  rp_pkg::sys_rsp_t  ctrl_rsp;
  rp_pkg::mix_mask_t mask;              // mixer source enables

  // ----------------------------------------
  // system bus
  sys_bus_fsm u_sys_bus_fsm (
    .adc_clk     (adc_clk),     .rst_i       (rst_i),
    .req_valid_i (req_valid_i), .req_i       (req_i),     .req_ready_o (req_ready_o),
    .rsp_valid_o (rsp_valid_o), .rsp_o       (rsp_o),     .rsp_ready_i (rsp_ready_i),
    .stb_o       (stb),         .bus_req_o   (bus_req),
    .ack_i       (ack),         .bus_rsp_i   (bus_rsp)
  );

  sys_bus_decoder u_sys_bus_decoder (
    .stb_i      (stb),      .bus_req_i  (bus_req),
    .ctrl_stb_o (ctrl_stb), .ctrl_ack_i (ctrl_ack), .ctrl_rsp_i (ctrl_rsp),
    .ack_o      (ack),      .bus_rsp_o  (bus_rsp)
  );

  // ----------------------------------------
  // region 0 and the mixer
  ctrl_regs u_ctrl_regs (
    .adc_clk (adc_clk),  .rst_i     (rst_i),
    .stb_i   (ctrl_stb), .bus_req_i (bus_req),
    .ack_o   (ctrl_ack), .rsp_o     (ctrl_rsp),
    .led_o   (led_o),    .mask_o    (mask)
  );

  dac_sat_sum u_dac_sat_sum (
    .adc_clk (adc_clk), .rst_i  (rst_i),
    .gen_i   (gen_i),   .pid_i  (pid_i),
    .mask_i  (mask),    .dac_o  (dac_o)
  );

endmodule

`default_nettype wire

// File: verification/tb_rp_top.sv
// Testbench for rp_top. Random DAC samples run all the time while bus
// transfers go out with random response back-pressure.
// A model of region 0 and the mixer feeds immediate assertions.
// Needs the common folder on the include path.

`timescale 1ns/1ps
`default_nettype none

`include "rp_config.svh"

module tb_rp_top;

  localparam int RST_CYCLES = 16;
  localparam int N_SAMPLES  = 200;          // plain sample traffic after reset
  localparam int N_OPS      = 40;           // bound on bus transfers
  localparam int OP_CYCLES  = 12;           // worst transfer incl. back-pressure
  localparam int CYC_LIMIT  = RST_CYCLES + N_SAMPLES + N_OPS * (OP_CYCLES + 20) + 100;
  localparam int S_MAX      = 2 ** (`RP_SAMPLE_W - 1) - 1;
  localparam int S_MIN      = -(2 ** (`RP_SAMPLE_W - 1));
  localparam logic [3:0] MASKS [6] = '{4'b0111, 4'b1011, 4'b1101, 4'b1110, 4'b0000, 4'b1111};
  localparam logic [3:0] LED_SELS [3] = '{4'b0001, 4'b1110, 4'b1111};

  logic              adc_clk;
  logic              rst_i;
  logic              req_valid_i;
  rp_pkg::sys_req_t  req_i;
  logic              req_ready_o;
  logic              rsp_valid_o;
  rp_pkg::sys_rsp_t  rsp_o;
  logic              rsp_ready_i;
  rp_pkg::dac_pair_t gen_i;
  rp_pkg::dac_pair_t pid_i;
  rp_pkg::dac_pair_t dac_o;
  logic [7:0]        led_o;

  rp_pkg::mix_mask_t model_mask;            // mask as the model sees it
  logic [7:0]        model_led;
  rp_pkg::dac_pair_t exp_q;                 // expected dac_o after last edge
  logic              exp_vld_q;
  logic              dac_chk;               // off while a mask write is in flight
  logic [1:0]        stim_mode;             // 0 random, 1 all max, 2 all min
  int                cyc;
  int                dac_errs;
  int                bus_errs;
  int                proto_errs;

  rp_top u_rp_top (
    .adc_clk     (adc_clk),     .rst_i       (rst_i),
    .req_valid_i (req_valid_i), .req_i       (req_i),  .req_ready_o (req_ready_o),
    .rsp_valid_o (rsp_valid_o), .rsp_o       (rsp_o),  .rsp_ready_i (rsp_ready_i),
    .gen_i       (gen_i),       .pid_i       (pid_i),
    .dac_o       (dac_o),       .led_o       (led_o)
  );

  always #50 adc_clk = ~adc_clk;            // 100 ns period

  // ----------------------------------------
  // mixer model clamps in plain integers
  function automatic rp_pkg::sample_t sat_model(input rp_pkg::sample_t x,
                                                input rp_pkg::sample_t y,
                                                input logic ex, input logic ey);
    int s;
    s = 0;
    if (ex) s += x;                         // signed, sign extended
    if (ey) s += y;
    if (s > S_MAX) s = S_MAX;
    else if (s < S_MIN) s = S_MIN;
    return s[`RP_SAMPLE_W-1:0];
  endfunction

  function automatic rp_pkg::sample_t pick_sample(input logic [1:0] mode);
    logic [31:0] r;
    r = $urandom;
    if (mode == 2'd1 || r[3:0] == 4'd0) return `RP_SAT_POS;  // extremes now and then
    if (mode == 2'd2 || r[3:0] == 4'd1) return `RP_SAT_NEG;
    return r[31:18];
  endfunction

  always @(posedge adc_clk) begin
    gen_i.a <= pick_sample(stim_mode);
    gen_i.b <= pick_sample(stim_mode);
    pid_i.a <= pick_sample(stim_mode);
    pid_i.b <= pick_sample(stim_mode);
  end

  always @(posedge adc_clk) begin
    exp_vld_q <= dac_chk;
    if (rst_i) begin
      exp_q <= '0;                          // outputs clear in reset
    end else begin
      exp_q.a <= sat_model(gen_i.a, pid_i.a, model_mask.gen_a, model_mask.ctl_a);
      exp_q.b <= sat_model(gen_i.b, pid_i.b, model_mask.gen_b, model_mask.ctl_b);
    end
  end

  always @(negedge adc_clk) begin           // dac_o settled by mid-cycle
    if (exp_vld_q) begin
      assert (dac_o.a == exp_q.a) else begin
        dac_errs++;
        $display("Error: %0t dac_o.a got %h expected %h", $time, dac_o.a, exp_q.a);
      end
      assert (dac_o.b == exp_q.b) else begin
        dac_errs++;
        $display("Error: %0t dac_o.b got %h expected %h", $time, dac_o.b, exp_q.b);
      end
    end
  end

  always @(posedge adc_clk) begin
    cyc <= cyc + 1;
    if (cyc == CYC_LIMIT) begin
      $display("timeout after %0d cycles, the bus sequence did not finish", cyc);
      $display("Checks failed");
      $finish;
    end
  end

  // ----------------------------------------
  // bus helpers are called right after a rising edge
  task automatic check_rsp(input string what, input rp_pkg::sys_rsp_t got,
                           input bit chk_data, input logic [31:0] rdata, input logic err);
    assert (!chk_data || got.rdata == rdata) else begin
      bus_errs++;
      $display("Error: %0t rsp_o.rdata (%s) got %h expected %h", $time, what, got.rdata, rdata);
    end
    assert (got.err == err) else begin
      bus_errs++;
      $display("Error: %0t rsp_o.err (%s) got %b expected %b", $time, what, got.err, err);
    end
  endtask

  task automatic bus_xfer(input logic [2:0] region, input logic [19:0] ofs, input logic wr,
                          input logic [31:0] wdata, input logic [3:0] sel,
                          output rp_pkg::sys_rsp_t rsp);
    rp_pkg::sys_req_t req;
    int waits;
    int hold;
    req.addr.raw           = '0;
    req.addr.fields.region = region;
    req.addr.fields.offset = ofs;
    req.wdata              = wdata;
    req.sel                = sel;
    req.wr                 = wr;
    hold                   = $urandom_range(5, 0);  // back-pressure cycles
    waits                  = 0;
    req_valid_i <= 1'b1;
    req_i       <= req;
    do begin
      @(posedge adc_clk);
      waits++;
    end while (!req_ready_o);
    req_valid_i <= 1'b0;
    assert (waits == 1) else begin          // bus idle so no wait expected
      proto_errs++;
      $display("request at %0t waited %0d cycles on an idle bus", $time, waits);
    end
    @(posedge adc_clk);
    while (!rsp_valid_o) @(posedge adc_clk);
    rsp = rsp_o;
    repeat (hold) begin
      @(posedge adc_clk);
      assert (rsp_valid_o && rsp_o == rsp && !req_ready_o) else begin
        proto_errs++;
        $display("response moved or bus reopened under back-pressure at %0t", $time);
      end
    end
    rsp_ready_i <= 1'b1;
    @(posedge adc_clk);                     // response taken here
    assert (rsp_valid_o && rsp_o == rsp) else begin
      proto_errs++;
      $display("response dropped before it was taken at %0t", $time);
    end
    rsp_ready_i <= 1'b0;
  endtask

  // ----------------------------------------
  // test sequence
  initial begin
    rp_pkg::sys_rsp_t  rsp;
    rp_pkg::mix_mask_t m;
    logic [31:0]       w;
    logic [3:0]        sel;
    int                i;
    void'($urandom(32'h5117_0b28));
    adc_clk     = 1'b0;
    rst_i       = 1'b1;
    req_valid_i = 1'b0;
    req_i       = '0;
    rsp_ready_i = 1'b0;
    gen_i       = '0;
    pid_i       = '0;
    model_mask  = '1;                       // all sources on after reset
    model_led   = 8'h00;
    dac_chk     = 1'b1;
    exp_vld_q   = 1'b0;
    stim_mode   = 2'd0;
    cyc         = 0;
    dac_errs    = 0;
    bus_errs    = 0;
    proto_errs  = 0;
    repeat (RST_CYCLES) @(posedge adc_clk);
    rst_i <= 1'b0;
    @(posedge adc_clk);
    assert (req_ready_o) else begin
      proto_errs++;
      $display("Error: %0t req_ready_o got %b expected 1", $time, req_ready_o);
    end
    assert (!rsp_valid_o) else begin
      proto_errs++;
      $display("Error: %0t rsp_valid_o got %b expected 0", $time, rsp_valid_o);
    end
    assert (led_o == 8'h00) else begin
      bus_errs++;
      $display("Error: %0t led_o got %h expected 00", $time, led_o);
    end
    repeat (N_SAMPLES) @(posedge adc_clk);  // random data with the default mix
    stim_mode <= 2'd1;                      // force positive overflow
    repeat (6) @(posedge adc_clk);
    stim_mode <= 2'd2;                      // force negative overflow
    repeat (6) @(posedge adc_clk);
    stim_mode <= 2'd0;

    for (i = 0; i < 6; i++) begin           // single sources off then all off and all on
      m = rp_pkg::mix_mask_t'(MASKS[i]);
      dac_chk <= 1'b0;
      bus_xfer(`RP_CTRL_REGION, `RP_OFS_MIX, 1'b1, {28'h0, m}, 4'hF, rsp);
      check_rsp("mix write", rsp, 1'b0, 32'h0, 1'b0);
      model_mask <= m;
      dac_chk    <= 1'b1;
      repeat (20) @(posedge adc_clk);
      bus_xfer(`RP_CTRL_REGION, `RP_OFS_MIX, 1'b0, 32'h0, 4'hF, rsp);
      check_rsp("mix readback", rsp, 1'b1, {28'h0, m}, 1'b0);
    end

    for (i = 0; i < 3; i++) begin           // led lives in byte 0 only
      w   = $urandom;
      sel = LED_SELS[i];
      bus_xfer(`RP_CTRL_REGION, `RP_OFS_LED, 1'b1, w, sel, rsp);
      check_rsp("led write", rsp, 1'b0, 32'h0, 1'b0);
      if (sel[0]) model_led = w[7:0];
      bus_xfer(`RP_CTRL_REGION, `RP_OFS_LED, 1'b0, 32'h0, 4'hF, rsp);
      check_rsp("led readback", rsp, 1'b1, {24'h0, model_led}, 1'b0);
      assert (led_o == model_led) else begin
        bus_errs++;
        $display("Error: %0t led_o got %h expected %h", $time, led_o, model_led);
      end
    end

    bus_xfer(`RP_CTRL_REGION, `RP_OFS_ID, 1'b0, 32'h0, 4'hF, rsp);
    check_rsp("id read", rsp, 1'b1, `RP_ID_VALUE, 1'b0);
    bus_xfer(`RP_CTRL_REGION, `RP_OFS_ID, 1'b1, ~`RP_ID_VALUE, 4'hF, rsp);
    check_rsp("id write", rsp, 1'b0, 32'h0, 1'b0);
    bus_xfer(`RP_CTRL_REGION, `RP_OFS_ID, 1'b0, 32'h0, 4'hF, rsp);
    check_rsp("id read after write", rsp, 1'b1, `RP_ID_VALUE, 1'b0);
    bus_xfer(`RP_CTRL_REGION, 20'h0000C, 1'b0, 32'h0, 4'hF, rsp);
    check_rsp("bad offset read", rsp, 1'b1, 32'h0, 1'b1);
    bus_xfer(`RP_CTRL_REGION, 20'h00100, 1'b1, $urandom, 4'hF, rsp);
    check_rsp("bad offset write", rsp, 1'b0, 32'h0, 1'b1);

    for (i = 1; i < `RP_REGION_NUM; i++) begin  // unmapped regions
      w = $urandom;
      bus_xfer(i[2:0], w[19:0], 1'b0, 32'h0, 4'hF, rsp);
      check_rsp("unmapped read", rsp, 1'b1, 32'h0, 1'b0);
      bus_xfer(i[2:0], w[19:0], 1'b1, $urandom, 4'hF, rsp);
      check_rsp("unmapped write", rsp, 1'b1, 32'h0, 1'b0);
    end

    repeat (4) @(posedge adc_clk);
    $display("errors: dac %0d, bus %0d, protocol %0d", dac_errs, bus_errs, proto_errs);
    if (dac_errs + bus_errs + proto_errs == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
+incdir+common
common/rp_pkg.sv
hw/sys_bus/sys_bus_fsm.sv
hw/sys_bus/sys_bus_decoder.sv
hw/dac_mix/ctrl_regs.sv
hw/dac_mix/dac_sat_sum.sv
hw/rp_top.sv
verification/tb_rp_top.sv

// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator, run it, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	rm -f $(LOG)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_rp_top -f compile.f
	./obj_dir/Vtb_rp_top | tee $(LOG)
	@if grep -q "^All checks passed$$" $(LOG); then \
	  echo "PASS"; \
	else \
	  echo "FAIL"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
